//--- design/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int ARCH_REG_SZ = 32;
    localparam int PHYS_REG_SZ = 64;

    typedef logic [4:0]  arn_t;
    typedef logic [5:0]  prn_t;
    typedef logic [4:0]  robn_t;
    typedef logic [31:0] word_t;

    // ALU_MUL is steered to the multiplier
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_MUL = 3'd6
    } alu_func_t;

    typedef struct packed {
        logic      valid;
        alu_func_t func;
        arn_t      dest_arn;
        arn_t      src1_arn;
        arn_t      src2_arn;
        logic      use_imm;
        word_t     imm;
    } id_packet_t;

    // a waiting operand keeps its prn in the low bits
    typedef struct packed {
        logic      valid;
        alu_func_t func;
        logic      op1_ready;
        word_t     op1;
        logic      op2_ready;
        word_t     op2;
        prn_t      dest_prn;
        robn_t     robn;
    } rs_entry_t;

    typedef struct packed {
        logic      valid;
        alu_func_t func;
        word_t     op1;
        word_t     op2;
        prn_t      dest_prn;
        robn_t     robn;
    } issue_packet_t;

    typedef struct packed {
        logic  valid;
        prn_t  dest_prn;
        robn_t robn;
        word_t value;
    } cdb_packet_t;

    typedef struct packed {
        arn_t dest_arn;
        prn_t dest_prn;
        prn_t old_prn;
        logic executed;
    } rob_entry_t;

    typedef struct packed {
        logic  valid;
        arn_t  wr_idx;
        logic  wr_en;
        word_t wr_data;
    } ct_packet_t;

endpackage

`default_nettype wire

//--- design/rat.sv
`timescale 1ns/1ps
`default_nettype none

module rat (
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      accept,
    input  wire ooo_pkg::id_packet_t id_packet,
    output ooo_pkg::prn_t            src1_prn,
    output ooo_pkg::prn_t            src2_prn,
    output ooo_pkg::prn_t            new_prn,
    output ooo_pkg::prn_t            old_prn,
    input  wire                      free_valid,
    input  wire ooo_pkg::prn_t       free_prn
);

    localparam int FREE_SZ = ooo_pkg::PHYS_REG_SZ - ooo_pkg::ARCH_REG_SZ;
    localparam int PTR_W   = $clog2(FREE_SZ);

    ooo_pkg::prn_t map [ooo_pkg::ARCH_REG_SZ];
    ooo_pkg::prn_t free_list [FREE_SZ];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic             rename;

    // arn 0 keeps prn 0 for good
    assign rename   = accept && (id_packet.dest_arn != '0);
    assign src1_prn = map[id_packet.src1_arn];
    assign src2_prn = map[id_packet.src2_arn];
    assign new_prn  = (id_packet.dest_arn == '0) ? '0 : free_list[head];
    assign old_prn  = map[id_packet.dest_arn];

    // list starts full, so head == tail means 32 free
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < ooo_pkg::ARCH_REG_SZ; i++) begin
                map[i] <= ooo_pkg::prn_t'(i);
            end
            for (int i = 0; i < FREE_SZ; i++) begin
                free_list[i] <= ooo_pkg::prn_t'(ooo_pkg::ARCH_REG_SZ + i);
            end
        end else begin
            if (rename) begin
                map[id_packet.dest_arn] <= free_list[head];
                head <= head + 1'b1;
            end
            if (free_valid) begin
                free_list[tail] <= free_prn;
                tail <= tail + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rrat.sv
`timescale 1ns/1ps
`default_nettype none

module rrat (
    input  wire                clock,
    input  wire                reset,
    input  wire                commit,
    input  wire ooo_pkg::arn_t commit_arn,
    input  wire ooo_pkg::prn_t commit_prn,
    output logic               free_valid,
    output ooo_pkg::prn_t      free_prn
);

    ooo_pkg::prn_t map [ooo_pkg::ARCH_REG_SZ];

    // displaced committed mapping goes back to the free list
    assign free_valid = commit && (commit_arn != '0);
    assign free_prn   = map[commit_arn];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::ARCH_REG_SZ; i++) begin
                map[i] <= ooo_pkg::prn_t'(i);
            end
        end else if (free_valid) begin
            map[commit_arn] <= commit_prn;
        end
    end

endmodule

`default_nettype wire

//--- design/prf.sv
`timescale 1ns/1ps
`default_nettype none

module prf (
    input  wire                       clock,
    input  wire                       reset,
    input  wire ooo_pkg::prn_t [2:0]  read_prn,
    output ooo_pkg::word_t [2:0]      read_value,
    output logic [2:0]                read_ready,
    input  wire                       alloc,
    input  wire ooo_pkg::prn_t        alloc_prn,
    input  wire ooo_pkg::cdb_packet_t cdb
);

    ooo_pkg::word_t value [ooo_pkg::PHYS_REG_SZ];
    logic [ooo_pkg::PHYS_REG_SZ-1:0] ready;
    logic cdb_write;

    // prn 0 is never written
    assign cdb_write = cdb.valid && (cdb.dest_prn != '0);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (cdb_write && (cdb.dest_prn == read_prn[i])) begin
                read_value[i] = cdb.value;
                read_ready[i] = 1'b1;
            end else begin
                read_value[i] = value[read_prn[i]];
                read_ready[i] = ready[read_prn[i]];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready <= '1;
            for (int i = 0; i < ooo_pkg::PHYS_REG_SZ; i++) begin
                value[i] <= '0;
            end
        end else begin
            if (alloc && (alloc_prn != '0)) begin
                ready[alloc_prn] <= 1'b0;
            end
            if (cdb_write) begin
                value[cdb.dest_prn] <= cdb.value;
                ready[cdb.dest_prn] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rs.sv
`timescale 1ns/1ps
`default_nettype none

module rs #(
    parameter int RS_SZ = 8
) (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       accept,
    input  wire ooo_pkg::rs_entry_t   entry,
    input  wire ooo_pkg::cdb_packet_t cdb,
    input  wire                       alu_avail,
    input  wire                       mult_avail,
    output ooo_pkg::issue_packet_t    alu_issue,
    output ooo_pkg::issue_packet_t    mult_issue,
    output logic                      full
);

    localparam int IDX_W = $clog2(RS_SZ);
    localparam int CNT_W = $clog2(RS_SZ + 1);

    ooo_pkg::rs_entry_t entries [RS_SZ];
    // number of valid entries older than this one
    logic [CNT_W-1:0] rank [RS_SZ];
    logic [CNT_W-1:0] count;
    logic [RS_SZ-1:0] alu_ready;
    logic [RS_SZ-1:0] mult_ready;
    logic             alu_found;
    logic             mult_found;
    logic [IDX_W-1:0] alu_sel;
    logic [IDX_W-1:0] mult_sel;
    logic [IDX_W-1:0] free_slot;
    logic             alu_take;
    logic             mult_take;

    // msb of the result flags a hit
    function automatic logic [IDX_W:0] oldest(input logic [RS_SZ-1:0] req);
        logic [IDX_W:0] pick;
        pick = '0;
        for (int i = 0; i < RS_SZ; i++) begin
            if (req[i] && (!pick[IDX_W] || rank[i] < rank[pick[IDX_W-1:0]])) begin
                pick = {1'b1, IDX_W'(i)};
            end
        end
        return pick;
    endfunction

    function automatic ooo_pkg::issue_packet_t to_issue(input ooo_pkg::rs_entry_t e,
                                                        input logic take);
        return '{valid: take, func: e.func, op1: e.op1, op2: e.op2,
                 dest_prn: e.dest_prn, robn: e.robn};
    endfunction

    always_comb begin
        for (int i = 0; i < RS_SZ; i++) begin
            alu_ready[i]  = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                            && (entries[i].func != ooo_pkg::ALU_MUL);
            mult_ready[i] = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                            && (entries[i].func == ooo_pkg::ALU_MUL);
        end
    end

    always_comb begin
        free_slot = '0;
        for (int i = RS_SZ - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_slot = IDX_W'(i);
            end
        end
    end

    assign {alu_found, alu_sel}   = oldest(alu_ready);
    assign {mult_found, mult_sel} = oldest(mult_ready);
    assign alu_take   = alu_found && alu_avail;
    assign mult_take  = mult_found && mult_avail;
    assign alu_issue  = to_issue(entries[alu_sel], alu_take);
    assign mult_issue = to_issue(entries[mult_sel], mult_take);
    assign full       = (count == CNT_W'(RS_SZ));

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            for (int i = 0; i < RS_SZ; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < RS_SZ; i++) begin
                // cdb wakeup
                if (cdb.valid && !entries[i].op1_ready
                    && (ooo_pkg::prn_t'(entries[i].op1) == cdb.dest_prn)) begin
                    entries[i].op1_ready <= 1'b1;
                    entries[i].op1       <= cdb.value;
                end
                if (cdb.valid && !entries[i].op2_ready
                    && (ooo_pkg::prn_t'(entries[i].op2) == cdb.dest_prn)) begin
                    entries[i].op2_ready <= 1'b1;
                    entries[i].op2       <= cdb.value;
                end
                rank[i] <= rank[i]
                           - CNT_W'(alu_take && (rank[alu_sel] < rank[i]))
                           - CNT_W'(mult_take && (rank[mult_sel] < rank[i]));
            end
            if (alu_take) begin
                entries[alu_sel].valid <= 1'b0;
            end
            if (mult_take) begin
                entries[mult_sel].valid <= 1'b0;
            end
            if (accept) begin
                entries[free_slot] <= entry;
                rank[free_slot]    <= count - CNT_W'(alu_take) - CNT_W'(mult_take);
            end
            count <= count + CNT_W'(accept) - CNT_W'(alu_take) - CNT_W'(mult_take);
        end
    end

endmodule

`default_nettype wire

//--- design/fu_cdb.sv
`timescale 1ns/1ps
`default_nettype none

module fu_cdb #(
    parameter int MULT_STAGES = 3
) (
    input  wire                         clock,
    input  wire                         reset,
    input  wire ooo_pkg::issue_packet_t alu_issue,
    input  wire ooo_pkg::issue_packet_t mult_issue,
    output logic                        alu_avail,
    output logic                        mult_avail,
    output ooo_pkg::cdb_packet_t        cdb
);

    ooo_pkg::cdb_packet_t alu_result;
    ooo_pkg::cdb_packet_t mult_pipe [MULT_STAGES];
    ooo_pkg::word_t       alu_value;

    always_comb begin
        case (alu_issue.func)
            ooo_pkg::ALU_SUB: alu_value = alu_issue.op1 - alu_issue.op2;
            ooo_pkg::ALU_AND: alu_value = alu_issue.op1 & alu_issue.op2;
            ooo_pkg::ALU_OR:  alu_value = alu_issue.op1 | alu_issue.op2;
            ooo_pkg::ALU_XOR: alu_value = alu_issue.op1 ^ alu_issue.op2;
            ooo_pkg::ALU_SLL: alu_value = alu_issue.op1 << alu_issue.op2[4:0];
            default:          alu_value = alu_issue.op1 + alu_issue.op2;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_result.valid <= 1'b0;
            for (int i = 0; i < MULT_STAGES; i++) begin
                mult_pipe[i].valid <= 1'b0;
            end
        end else begin
            alu_result <= '{valid: alu_issue.valid, dest_prn: alu_issue.dest_prn,
                            robn: alu_issue.robn, value: alu_value};
            // product formed in the first stage, then carried along
            mult_pipe[0] <= '{valid: mult_issue.valid, dest_prn: mult_issue.dest_prn,
                              robn: mult_issue.robn,
                              value: mult_issue.op1 * mult_issue.op2};
            for (int i = 1; i < MULT_STAGES; i++) begin
                mult_pipe[i] <= mult_pipe[i-1];
            end
        end
    end

    // alu gives up the cdb slot one cycle before a product lands
    assign alu_avail  = !mult_pipe[MULT_STAGES-2].valid;
    assign mult_avail = 1'b1;
    assign cdb        = alu_result.valid ? alu_result : mult_pipe[MULT_STAGES-1];

endmodule

`default_nettype wire

//--- design/rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int ROB_SZ = 16
) (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       accept,
    input  wire ooo_pkg::rob_entry_t  entry,
    output ooo_pkg::robn_t            tail,
    input  wire ooo_pkg::cdb_packet_t cdb,
    output ooo_pkg::rob_entry_t       head_entry,
    output logic                      commit,
    output logic                      full
);

    localparam int PTR_W = $clog2(ROB_SZ);
    localparam int CNT_W = PTR_W + 1;

    ooo_pkg::rob_entry_t entries [ROB_SZ];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;

    assign tail       = ooo_pkg::robn_t'(tail_ptr);
    assign head_entry = entries[head_ptr];
    assign commit     = (count != '0) && head_entry.executed;
    assign full       = (count == CNT_W'(ROB_SZ));

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (accept) begin
                entries[tail_ptr] <= entry;
                tail_ptr <= tail_ptr + 1'b1;
            end
            // completion, possibly out of order
            if (cdb.valid) begin
                entries[cdb.robn[PTR_W-1:0]].executed <= 1'b1;
            end
            if (commit) begin
                head_ptr <= head_ptr + 1'b1;
            end
            count <= count + CNT_W'(accept) - CNT_W'(commit);
        end
    end

endmodule

`default_nettype wire

//--- design/ooo.sv
`timescale 1ns/1ps
`default_nettype none

module ooo #(
    parameter int ROB_SZ      = 16,
    parameter int RS_SZ       = 8,
    parameter int MULT_STAGES = 3
) (
    input  wire                      clock,
    input  wire                      reset,
    input  wire ooo_pkg::id_packet_t id_packet,
    output logic                     structural_hazard,
    output ooo_pkg::ct_packet_t      ct_packet
);

    logic                   accept;
    logic                   rs_full;
    logic                   rob_full;
    logic                   rob_commit;
    ooo_pkg::prn_t          src1_prn;
    ooo_pkg::prn_t          src2_prn;
    ooo_pkg::prn_t          new_prn;
    ooo_pkg::prn_t          old_prn;
    logic                   free_valid;
    ooo_pkg::prn_t          free_prn;
    ooo_pkg::prn_t [2:0]    read_prn;
    ooo_pkg::word_t [2:0]   read_value;
    logic [2:0]             read_ready;
    ooo_pkg::rs_entry_t     rs_entry;
    ooo_pkg::rob_entry_t    rob_entry;
    ooo_pkg::rob_entry_t    head_entry;
    ooo_pkg::robn_t         rob_tail;
    ooo_pkg::issue_packet_t alu_issue;
    ooo_pkg::issue_packet_t mult_issue;
    logic                   alu_avail;
    logic                   mult_avail;
    ooo_pkg::cdb_packet_t   cdb;

    // both fullness flags come from registered counts
    assign structural_hazard = rs_full || rob_full;
    assign accept            = id_packet.valid && !structural_hazard;

    // port 2 reads the retiring value
    assign read_prn = {head_entry.dest_prn, src2_prn, src1_prn};

    always_comb begin
        rs_entry.valid     = id_packet.valid;
        rs_entry.func      = id_packet.func;
        rs_entry.op1_ready = read_ready[0];
        rs_entry.op1       = read_ready[0] ? read_value[0] : ooo_pkg::word_t'(src1_prn);
        if (id_packet.use_imm) begin
            rs_entry.op2_ready = 1'b1;
            rs_entry.op2       = id_packet.imm;
        end else begin
            rs_entry.op2_ready = read_ready[1];
            rs_entry.op2       = read_ready[1] ? read_value[1] : ooo_pkg::word_t'(src2_prn);
        end
        rs_entry.dest_prn  = new_prn;
        rs_entry.robn      = rob_tail;

        rob_entry.dest_arn = id_packet.dest_arn;
        rob_entry.dest_prn = new_prn;
        rob_entry.old_prn  = old_prn;
        rob_entry.executed = 1'b0;
    end

    always_comb begin
        ct_packet.valid   = rob_commit;
        ct_packet.wr_idx  = head_entry.dest_arn;
        ct_packet.wr_en   = (head_entry.dest_arn != '0);
        ct_packet.wr_data = read_value[2];
    end

    rat u_rat (
        .clock      (clock),
        .reset      (reset),
        .accept     (accept),
        .id_packet  (id_packet),
        .src1_prn   (src1_prn),
        .src2_prn   (src2_prn),
        .new_prn    (new_prn),
        .old_prn    (old_prn),
        .free_valid (free_valid),
        .free_prn   (free_prn)
    );

    rrat u_rrat (
        .clock      (clock),
        .reset      (reset),
        .commit     (rob_commit),
        .commit_arn (head_entry.dest_arn),
        .commit_prn (head_entry.dest_prn),
        .free_valid (free_valid),
        .free_prn   (free_prn)
    );

    prf u_prf (
        .clock      (clock),
        .reset      (reset),
        .read_prn   (read_prn),
        .read_value (read_value),
        .read_ready (read_ready),
        .alloc      (accept),
        .alloc_prn  (new_prn),
        .cdb        (cdb)
    );

    rs #(.RS_SZ(RS_SZ)) u_rs (
        .clock      (clock),
        .reset      (reset),
        .accept     (accept),
        .entry      (rs_entry),
        .cdb        (cdb),
        .alu_avail  (alu_avail),
        .mult_avail (mult_avail),
        .alu_issue  (alu_issue),
        .mult_issue (mult_issue),
        .full       (rs_full)
    );

    fu_cdb #(.MULT_STAGES(MULT_STAGES)) u_fu_cdb (
        .clock      (clock),
        .reset      (reset),
        .alu_issue  (alu_issue),
        .mult_issue (mult_issue),
        .alu_avail  (alu_avail),
        .mult_avail (mult_avail),
        .cdb        (cdb)
    );

    rob #(.ROB_SZ(ROB_SZ)) u_rob (
        .clock      (clock),
        .reset      (reset),
        .accept     (accept),
        .entry      (rob_entry),
        .tail       (rob_tail),
        .cdb        (cdb),
        .head_entry (head_entry),
        .commit     (rob_commit),
        .full       (rob_full)
    );

endmodule

`default_nettype wire

//--- test/ooo_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_assert #(
    parameter int ROB_SZ = 16
) (
    input wire                      clock,
    input wire                      reset,
    input wire ooo_pkg::id_packet_t id_packet,
    input wire                      structural_hazard,
    input wire ooo_pkg::ct_packet_t ct_packet,
    input wire                      rob_commit,
    input wire ooo_pkg::rob_entry_t head_entry,
    input wire                      free_valid,
    input wire ooo_pkg::prn_t       free_prn
);

    logic accept;
    logic commit;
    int   in_flight;

    assign accept = id_packet.valid && !structural_hazard;
    assign commit = ct_packet.valid;

    // accepted and not yet retired
    always_ff @(posedge clock) begin
        if (reset) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(accept) - int'(commit);
        end
    end

    a_reset_quiet: assert property (@(posedge clock)
        reset |=> !structural_hazard && !ct_packet.valid)
        else $error("hazard or commit active right after reset");

    a_wr_en: assert property (@(posedge clock) disable iff (reset)
        ct_packet.valid |-> (ct_packet.wr_en == (ct_packet.wr_idx != '0)))
        else $error("wr_en does not match wr_idx");

    a_rob_bound: assert property (@(posedge clock) disable iff (reset)
        in_flight <= ROB_SZ)
        else $error("more instructions in flight than ROB entries");

    a_full_hazard: assert property (@(posedge clock) disable iff (reset)
        (in_flight == ROB_SZ) |-> structural_hazard)
        else $error("ROB full without structural hazard");

    // upstream holds a stalled instruction
    a_hold: assert property (@(posedge clock) disable iff (reset)
        (id_packet.valid && structural_hazard) |=> $stable(id_packet))
        else $error("stalled instruction changed");

    // retirement frees the mapping that rename displaced
    a_old_prn: assert property (@(posedge clock) disable iff (reset)
        (rob_commit && (head_entry.dest_arn != '0))
            |-> (free_valid && (free_prn == head_entry.old_prn)))
        else $error("freed prn differs from the old mapping held in the ROB");

endmodule

bind ooo ooo_assert #(.ROB_SZ(ROB_SZ)) u_ooo_assert (
    .clock             (clock),
    .reset             (reset),
    .id_packet         (id_packet),
    .structural_hazard (structural_hazard),
    .ct_packet         (ct_packet),
    .rob_commit        (rob_commit),
    .head_entry        (head_entry),
    .free_valid        (free_valid),
    .free_prn          (free_prn)
);

`default_nettype wire

//--- test/ooo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_tb;

    localparam int NUM_INSTR      = 400;
    localparam int CHAIN_LEN      = 6;
    localparam int BURST_LEN      = 20;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 10 + 200;
    localparam logic [31:0] SEED  = 32'h138a;

    typedef struct packed {
        ooo_pkg::arn_t  idx;
        ooo_pkg::word_t data;
    } commit_t;

    logic                clock = 1'b0;
    logic                reset;
    ooo_pkg::id_packet_t id_packet;
    logic                structural_hazard;
    ooo_pkg::ct_packet_t ct_packet;

    commit_t        expected [$];
    ooo_pkg::word_t regs [ooo_pkg::ARCH_REG_SZ];
    int             accepted    = 0;
    int             committed   = 0;
    int             errors      = 0;
    int             cycle_count = 0;

    ooo u_ooo (
        .clock             (clock),
        .reset             (reset),
        .id_packet         (id_packet),
        .structural_hazard (structural_hazard),
        .ct_packet         (ct_packet)
    );

    always #5 clock = ~clock;

    function automatic ooo_pkg::word_t apply(input ooo_pkg::alu_func_t func,
                                             input ooo_pkg::word_t a,
                                             input ooo_pkg::word_t b);
        case (func)
            ooo_pkg::ALU_ADD: return a + b;
            ooo_pkg::ALU_SUB: return a - b;
            ooo_pkg::ALU_AND: return a & b;
            ooo_pkg::ALU_OR:  return a | b;
            ooo_pkg::ALU_XOR: return a ^ b;
            ooo_pkg::ALU_SLL: return a << b[4:0];
            ooo_pkg::ALU_MUL: return a * b;
            default:          return '0;
        endcase
    endfunction

    // each block of 100 opens with a multiply chain on r1, then independent alu ops
    function automatic ooo_pkg::id_packet_t make_instr(input int n);
        ooo_pkg::id_packet_t p;
        int pos;
        pos = n % 100;
        p = '0;
        p.valid = 1'b1;
        p.imm = $urandom();
        if (pos < CHAIN_LEN) begin
            p.func     = ooo_pkg::ALU_MUL;
            p.dest_arn = ooo_pkg::arn_t'(1);
            p.src1_arn = ooo_pkg::arn_t'(1);
            p.src2_arn = ooo_pkg::arn_t'(2);
        end else if (pos < BURST_LEN) begin
            p.func     = ooo_pkg::alu_func_t'($urandom_range(0, 5));
            p.dest_arn = ooo_pkg::arn_t'($urandom_range(3, 7));
            // r2 is not written inside the burst
            p.src1_arn = ooo_pkg::arn_t'(2);
            p.use_imm  = 1'b1;
        end else begin
            if ($urandom_range(0, 2) == 0) begin
                p.func = ooo_pkg::ALU_MUL;
            end else begin
                p.func = ooo_pkg::alu_func_t'($urandom_range(0, 5));
            end
            p.dest_arn = ooo_pkg::arn_t'($urandom_range(0, 7));
            p.src1_arn = ooo_pkg::arn_t'($urandom_range(0, 7));
            p.src2_arn = ooo_pkg::arn_t'($urandom_range(0, 7));
            p.use_imm  = ($urandom_range(0, 3) == 0);
        end
        return p;
    endfunction

    task automatic idle(input int count);
        repeat (count) begin
            @(posedge clock);
            id_packet <= '0;
        end
    endtask

    // returns once the packet will be taken at the next rising edge
    task automatic send(input ooo_pkg::id_packet_t p);
        @(posedge clock);
        id_packet <= p;
        @(negedge clock);
        while (structural_hazard) begin
            @(negedge clock);
        end
    endtask

    // reference model and commit checks, sampled mid-cycle
    always @(negedge clock) begin
        commit_t        exp;
        ooo_pkg::word_t op1;
        ooo_pkg::word_t op2;
        if (!reset) begin
            if (ct_packet.valid) begin
                committed++;
                assert (expected.size() != 0) else begin
                    errors++;
                    $display("[ERROR] %0t commit with no instruction outstanding", $time);
                end
                if (expected.size() != 0) begin
                    exp = expected.pop_front();
                    assert (ct_packet.wr_idx == exp.idx) else begin
                        errors++;
                        $display("[ERROR] %0t wr_idx %0d, expected %0d",
                                 $time, ct_packet.wr_idx, exp.idx);
                    end
                    assert (ct_packet.wr_data == exp.data) else begin
                        errors++;
                        $display("[ERROR] %0t r%0d wr_data %h, expected %h",
                                 $time, exp.idx, ct_packet.wr_data, exp.data);
                    end
                end
                assert (ct_packet.wr_en == (ct_packet.wr_idx != '0)) else begin
                    errors++;
                    $display("[ERROR] %0t wr_en %b for r%0d",
                             $time, ct_packet.wr_en, ct_packet.wr_idx);
                end
            end
            if (id_packet.valid && !structural_hazard) begin
                accepted++;
                op1 = regs[id_packet.src1_arn];
                op2 = id_packet.use_imm ? id_packet.imm : regs[id_packet.src2_arn];
                if (id_packet.dest_arn != '0) begin
                    regs[id_packet.dest_arn] = apply(id_packet.func, op1, op2);
                end
                expected.push_back(commit_t'{idx: id_packet.dest_arn,
                                             data: regs[id_packet.dest_arn]});
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: run hung after %0d cycles, %0d commits still outstanding",
                     cycle_count, expected.size());
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        id_packet = '0;
        void'($urandom(SEED));
        for (int i = 0; i < ooo_pkg::ARCH_REG_SZ; i++) begin
            regs[i] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            if ((n % 100) >= BURST_LEN && $urandom_range(0, 3) == 0) begin
                idle($urandom_range(1, 3));
            end
            send(make_instr(n));
        end
        idle(1);
        while (expected.size() != 0) begin
            @(negedge clock);
        end
        // catch any stray commit after the drain
        repeat (20) @(negedge clock);
        assert (expected.size() == 0 && committed == accepted) else begin
            errors++;
            $display("[ERROR] %0t %0d accepted but %0d committed", $time, accepted, committed);
        end
        $display("accepted %0d, committed %0d, errors %0d", accepted, committed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/ooo_pkg.sv
design/rat.sv
design/rrat.sv
design/prf.sv
design/rs.sv
design/fu_cdb.sv
design/rob.sv
design/ooo.sv
test/ooo_assert.sv
test/ooo_tb.sv

//--- Makefile
TOP := ooo_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir
